// File: Makefile
# Verilator flow for the interval timer testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_pit: files.f $(wildcard src/*.sv include/*.svh sim/*.sv sim/*.svh)
	verilator --binary --timing --assert -f files.f --top-module tb_pit -o Vtb_pit

# a failing check ends in $fatal, which gives a non-zero exit status
run: obj_dir/Vtb_pit
	./obj_dir/Vtb_pit

lint:
	verilator --lint-only --timing --assert -Wall -f files.f --top-module tb_pit

clean:
	rm -rf obj_dir

// File: files.f
+incdir+include
+incdir+sim
src/pit_pkg.sv
src/pit_chan_if.sv
src/pit_regs.sv
src/pit_counter.sv
src/pit_top.sv
sim/tb_pit.sv

// File: include/pit_macros.svh
`ifndef PIT_MACROS_SVH
`define PIT_MACROS_SVH

// ========================================
// sizes
// ========================================
`define PIT_NTIMER 4
`define PIT_BITS 32
`define PIT_DW 32
`define PIT_AW 9

// per channel offsets inside a 0x10 stride
`define PIT_OFS_COUNT 4'h0
`define PIT_OFS_MAX 4'h4
`define PIT_OFS_ONT 4'h8
`define PIT_OFS_CTRL 4'hC

// ========================================
// global registers
// ========================================
`define PIT_REG_UFLOW 9'h100
`define PIT_REG_SYNC 9'h104
`define PIT_REG_IE 9'h108
`define PIT_REG_OUT 9'h10C
`define PIT_REG_IGATE 9'h110
`define PIT_REG_IGSET 9'h114
`define PIT_REG_IGCLR 9'h118

`endif

// File: sim/tb_pit_checks.svh
// ========================================
// failure handling
// ========================================
// every failing check ends here
task automatic stop_with_failure();
	$display("TB FAILED");
	$fatal(1, "run aborted on the first failing check");
endtask

// compare one value with its expected value
task automatic check_value(input string what, input logic [`PIT_DW-1:0] got,
	input logic [`PIT_DW-1:0] exp);
	assert (got === exp) else begin
		$display("** Error [%0t] %s: got %0h, expected %0h", $time, what, got, exp);
		stop_with_failure();
	end
endtask

// ========================================
// handshake rules
// ========================================
// ack only rises at an edge that saw req high
ack_needs_req: assert property (@(posedge clk) disable iff (rst)
	$rose(ack_o) |-> $past(req_i)) else begin
	$display("ack_o rose at %0t although req_i was low", $time);
	stop_with_failure();
end

// ack drops only once req is gone
ack_waits_req: assert property (@(posedge clk) disable iff (rst)
	$fell(ack_o) |-> !$past(req_i)) else begin
	$display("ack_o fell at %0t while req_i was still high", $time);
	stop_with_failure();
end

// ========================================
// pulse-width output
// ========================================
// out is high while the count runs from ont-1 down to zero,
// one period holds the counts max down to zero
task automatic check_pwm(input int ch, input int maxv, input int ontv);
	int cyc;
	int rise0;
	int fall0;
	int rise1;
	logic prev;
	cyc = 0;
	rise0 = -1;
	fall0 = -1;
	rise1 = -1;
	prev = out_o[ch];
	while (rise1 < 0) begin
		@(posedge clk);
		#1;
		cyc++;
		if (cyc > 4 * (maxv + 1) + 8) begin
			$display("out_o[%0d] did not rise twice within %0d cycles", ch, cyc);
			stop_with_failure();
		end
		if (!prev && out_o[ch]) begin
			if (rise0 < 0) begin
				rise0 = cyc;
			end else begin
				rise1 = cyc;
			end
		end
		// first falling edge after the first rise
		if (prev && !out_o[ch] && rise0 >= 0 && fall0 < 0) begin
			fall0 = cyc;
		end
		prev = out_o[ch];
	end
	check_value("pwm period", rise1 - rise0, maxv + 1);
	check_value("pwm high time", fall0 - rise0, ontv);
endtask

// File: sim/tb_pit.sv
`timescale 1ns/1ps
`include "pit_macros.svh"

module tb_pit;

	// watchdog budget, ten times a rough estimate of the run
	localparam int BUS_ACCESSES = 150;
	localparam int CYCLES_PER_ACCESS = 8;
	localparam int PIN_CYCLES = 800;
	localparam int WATCHDOG_CYCLES = 10 * (BUS_ACCESSES * CYCLES_PER_ACCESS + PIN_CYCLES);
	localparam int ACK_LIMIT = 16;

	logic clk;
	logic rst;
	logic req_i;
	logic we_i;
	logic [`PIT_AW-1:0] addr_i;
	logic [`PIT_DW-1:0] wdata_i;
	logic ack_o;
	logic [`PIT_DW-1:0] rdata_o;
	logic [`PIT_NTIMER-1:0] ext_clk_i;
	logic [`PIT_NTIMER-1:0] gate_i;
	logic [`PIT_NTIMER-1:0] out_o;
	logic irq_o;

	integer seed;
	logic [`PIT_DW-1:0] rd;
	int polls;
	int exp_count;

	pit_top i_pit_top (
		.clk(clk),
		.rst(rst),
		.req_i(req_i),
		.we_i(we_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.ack_o(ack_o),
		.rdata_o(rdata_o),
		.ext_clk_i(ext_clk_i),
		.gate_i(gate_i),
		.out_o(out_o),
		.irq_o(irq_o)
	);

	`include "tb_pit_checks.svh"

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, sequence did not finish", WATCHDOG_CYCLES);
		stop_with_failure();
	end

	// ========================================
	// bus helpers
	// ========================================
	function automatic logic [`PIT_AW-1:0] chan_addr(input int ch, input logic [3:0] ofs);
		return `PIT_AW'(ch * 16 + int'(ofs));
	endfunction

	// control byte, bit 0 upward: ld ce ar xc ge, two spare, commit
	function automatic logic [`PIT_DW-1:0] ctrl_word(input logic ld, input logic ce,
		input logic ar, input logic xc, input logic ge, input logic commit);
		return {{(`PIT_DW-8){1'b0}}, commit, 2'b00, ge, xc, ar, ce, ld};
	endfunction

	task automatic idle_wait();
		int n;
		n = {$random(seed)} % 4;
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			#1;
			n++;
			if (n > ACK_LIMIT) begin
				$display("ack_o did not go to %0b within %0d cycles", level, ACK_LIMIT);
				stop_with_failure();
			end
		end while (ack_o !== level);
	endtask

	task automatic bus_write(input logic [`PIT_AW-1:0] addr, input logic [`PIT_DW-1:0] data);
		idle_wait();
		@(posedge clk);
		#1;
		req_i = 1'b1;
		we_i = 1'b1;
		addr_i = addr;
		wdata_i = data;
		wait_ack(1'b1);
		req_i = 1'b0;
		we_i = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic bus_read(input logic [`PIT_AW-1:0] addr, output logic [`PIT_DW-1:0] data);
		idle_wait();
		@(posedge clk);
		#1;
		req_i = 1'b1;
		we_i = 1'b0;
		addr_i = addr;
		wait_ack(1'b1);
		// read data is valid together with ack
		data = rdata_o;
		req_i = 1'b0;
		wait_ack(1'b0);
	endtask

	// pulses start at least four cycles apart
	task automatic pulse_ext(input int ch, input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			ext_clk_i[ch] = 1'b1;
			repeat (2) @(posedge clk);
			#1;
			ext_clk_i[ch] = 1'b0;
			repeat (2) @(posedge clk);
			idle_wait();
		end
		// let the last edge through the synchronizer
		repeat (4) @(posedge clk);
	endtask

	// ========================================
	// stimulus
	// ========================================
	initial begin
		seed = 32'hfe5e;
		rst = 1'b1;
		req_i = 1'b0;
		we_i = 1'b0;
		addr_i = '0;
		wdata_i = '0;
		ext_clk_i = '0;
		gate_i = '0;
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;

		// shadow values stay hidden until commit
		bus_write(chan_addr(0, `PIT_OFS_MAX), 32'd100);
		bus_write(chan_addr(0, `PIT_OFS_ONT), 32'd20);
		bus_read(chan_addr(0, `PIT_OFS_MAX), rd);
		check_value("ch0 max before commit", rd, 32'd0);
		bus_read(chan_addr(0, `PIT_OFS_ONT), rd);
		check_value("ch0 ont before commit", rd, 32'd0);
		bus_write(chan_addr(0, `PIT_OFS_CTRL), ctrl_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
		bus_read(chan_addr(0, `PIT_OFS_MAX), rd);
		check_value("ch0 max after commit", rd, 32'd100);
		bus_read(chan_addr(0, `PIT_OFS_ONT), rd);
		check_value("ch0 ont after commit", rd, 32'd20);
		bus_read(chan_addr(0, `PIT_OFS_CTRL), rd);
		check_value("ch0 ctrl after commit", rd,
			ctrl_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));

		// one-shot on ch1, stops at zero
		bus_write(chan_addr(1, `PIT_OFS_MAX), 32'd50);
		bus_write(chan_addr(1, `PIT_OFS_ONT), 32'd10);
		bus_write(chan_addr(1, `PIT_OFS_CTRL), ctrl_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
		polls = 0;
		rd = '0;
		while (rd[1] !== 1'b1) begin
			bus_read(`PIT_REG_UFLOW, rd);
			polls++;
			if (polls > 100) begin
				$display("ch1 underflow status never set after %0d polls", polls);
				stop_with_failure();
			end
		end
		bus_read(chan_addr(1, `PIT_OFS_COUNT), rd);
		check_value("ch1 count after one-shot", rd, 32'd0);
		bus_read(chan_addr(1, `PIT_OFS_CTRL), rd);
		check_value("ch1 ctrl after one-shot", rd,
			ctrl_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0));
		bus_write(`PIT_REG_UFLOW, 32'h2);
		bus_read(`PIT_REG_UFLOW, rd);
		check_value("uflow after clear", rd, 32'h0);

		// auto-reload pwm on ch2
		bus_write(chan_addr(2, `PIT_OFS_MAX), 32'd9);
		bus_write(chan_addr(2, `PIT_OFS_ONT), 32'd3);
		bus_write(chan_addr(2, `PIT_OFS_CTRL), ctrl_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1));
		check_pwm(2, 9, 3);
		bus_write(chan_addr(2, `PIT_OFS_CTRL), ctrl_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
		// reloads of ch2 leave its status bit set
		bus_read(`PIT_REG_UFLOW, rd);
		check_value("uflow after pwm", rd, 32'h4);
		bus_write(`PIT_REG_UFLOW, 32'h4);

		// external clock on ch3, ont above max keeps out quiet
		exp_count = 1000;
		bus_write(chan_addr(3, `PIT_OFS_MAX), 32'd1000);
		bus_write(chan_addr(3, `PIT_OFS_ONT), 32'd2000);
		bus_write(chan_addr(3, `PIT_OFS_CTRL), ctrl_word(1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1));
		bus_read(chan_addr(3, `PIT_OFS_COUNT), rd);
		check_value("ch3 count after load", rd, exp_count);
		pulse_ext(3, 5);
		exp_count = exp_count - 5;
		bus_read(chan_addr(3, `PIT_OFS_COUNT), rd);
		check_value("ch3 count after ext pulses", rd, exp_count);
		// gate enabled, igate open and pin low
		bus_write(chan_addr(3, `PIT_OFS_CTRL), ctrl_word(1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1));
		bus_write(`PIT_REG_IGSET, 32'h8);
		bus_read(`PIT_REG_IGATE, rd);
		check_value("igate after set", rd, 32'h8);
		pulse_ext(3, 3);
		bus_read(chan_addr(3, `PIT_OFS_COUNT), rd);
		check_value("ch3 count with gate pin low", rd, exp_count);
		@(posedge clk);
		#1;
		gate_i[3] = 1'b1;
		pulse_ext(3, 2);
		exp_count = exp_count - 2;
		bus_read(chan_addr(3, `PIT_OFS_COUNT), rd);
		check_value("ch3 count with gate open", rd, exp_count);
		// pin high, igate closed
		bus_write(`PIT_REG_IGCLR, 32'h8);
		bus_read(`PIT_REG_IGATE, rd);
		check_value("igate after clear", rd, 32'h0);
		pulse_ext(3, 2);
		bus_read(chan_addr(3, `PIT_OFS_COUNT), rd);
		check_value("ch3 count with igate low", rd, exp_count);
		bus_write(chan_addr(3, `PIT_OFS_CTRL), ctrl_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
		gate_i[3] = 1'b0;

		// interrupt from a ch0 one-shot
		check_value("irq before underflow", 32'(irq_o), 32'h0);
		bus_write(`PIT_REG_IE, 32'h1);
		bus_write(chan_addr(0, `PIT_OFS_MAX), 32'd5);
		bus_write(chan_addr(0, `PIT_OFS_ONT), 32'd2);
		bus_write(chan_addr(0, `PIT_OFS_CTRL), ctrl_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
		polls = 0;
		while (irq_o !== 1'b1) begin
			@(posedge clk);
			#1;
			polls++;
			if (polls > 64) begin
				$display("irq_o did not rise within %0d cycles of the ch0 load", polls);
				stop_with_failure();
			end
		end
		bus_read(`PIT_REG_UFLOW, rd);
		check_value("uflow with irq", rd, 32'h1);
		bus_write(`PIT_REG_UFLOW, 32'h1);
		check_value("irq after uflow clear", 32'(irq_o), 32'h0);
		bus_read(`PIT_REG_UFLOW, rd);
		check_value("uflow after irq clear", rd, 32'h0);
		bus_read(`PIT_REG_IE, rd);
		check_value("ie after uflow clear", rd, 32'h0);

		// sync loads ch0 and ch2 together, ch1 holds a pending shadow load
		bus_write(chan_addr(0, `PIT_OFS_MAX), 32'h1234);
		bus_write(chan_addr(0, `PIT_OFS_ONT), 32'h10);
		bus_write(chan_addr(0, `PIT_OFS_CTRL), ctrl_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		bus_write(chan_addr(1, `PIT_OFS_MAX), 32'h9abc);
		bus_write(chan_addr(1, `PIT_OFS_CTRL), ctrl_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		bus_write(chan_addr(2, `PIT_OFS_MAX), 32'h5678);
		bus_write(chan_addr(2, `PIT_OFS_ONT), 32'h20);
		bus_write(chan_addr(2, `PIT_OFS_CTRL), ctrl_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0));
		bus_write(`PIT_REG_SYNC, 32'h5);
		bus_read(chan_addr(0, `PIT_OFS_COUNT), rd);
		check_value("ch0 count after sync", rd, 32'h1234);
		bus_read(chan_addr(2, `PIT_OFS_COUNT), rd);
		check_value("ch2 count after sync", rd, 32'h5678);
		bus_read(chan_addr(0, `PIT_OFS_MAX), rd);
		check_value("ch0 max after sync", rd, 32'h1234);
		bus_read(chan_addr(1, `PIT_OFS_COUNT), rd);
		check_value("ch1 count after sync", rd, 32'h0);
		bus_read(chan_addr(1, `PIT_OFS_MAX), rd);
		check_value("ch1 max after sync", rd, 32'd50);

		$display("TB PASSED");
		$finish;
	end

endmodule

// File: src/pit_chan_if.sv
`timescale 1ns/1ps
`include "pit_macros.svh"

// link between the register block and one channel counter
interface pit_chan_if;

	// from the register block
	// load request, one clock wide
	logic ld;
	// active count enable
	logic ce_set;
	logic ar;
	logic xc;
	logic ge;
	// software gate bit of this channel
	logic igate;
	logic [`PIT_BITS-1:0] maxcount;
	logic [`PIT_BITS-1:0] ont;

	// from the counter
	logic [`PIT_BITS-1:0] count;
	logic out;
	// underflow tick, one clock wide
	logic uflow;
	// no-reload channel hit zero, ce must drop
	logic stopped;

	modport regs (
		output ld, ce_set, ar, xc, ge, igate, maxcount, ont,
		input count, out, uflow, stopped
	);

	modport counter (
		input ld, ce_set, ar, xc, ge, igate, maxcount, ont,
		output count, out, uflow, stopped
	);

endinterface

// File: src/pit_counter.sv
`timescale 1ns/1ps
`include "pit_macros.svh"

module pit_counter (
	input logic clk,
	input logic rst,
	input logic ext_clk_i,
	input logic gate_i,
	pit_chan_if.counter ch
);

	// two sync flops plus one history flop for the edge
	logic [2:0] xsync;
	logic xedge;
	logic clk_ok;
	logic gate_ok;
	logic tick;

	logic [`PIT_BITS-1:0] count_q;
	logic out_q;
	logic uflow_q;
	logic stopped_q;

	// ========================================
	// external clock sync and edge detect
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			xsync <= '0;
		end else begin
			xsync <= {xsync[1:0], ext_clk_i};
		end
	end

	// rising edge after the second sync flop
	assign xedge = xsync[1] && !xsync[2];

	// tick needs enable, a clock source and an open gate
	assign clk_ok = !ch.xc || xedge;
	assign gate_ok = !ch.ge || (ch.igate && gate_i);
	// a stopped channel waits one clock for ce to drop
	assign tick = ch.ce_set && clk_ok && gate_ok && !stopped_q;

	// ========================================
	// down counter and pulse output
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
			out_q <= 1'b0;
			uflow_q <= 1'b0;
			stopped_q <= 1'b0;
		end else begin
			uflow_q <= 1'b0;
			stopped_q <= 1'b0;
			// load beats a tick in the same cycle
			if (ch.ld) begin
				count_q <= ch.maxcount;
			end else if (tick) begin
				if (count_q == ch.ont) begin
					out_q <= 1'b1;
					count_q <= count_q - 1'b1;
				end else if (count_q == '0) begin
					uflow_q <= 1'b1;
					out_q <= 1'b0;
					if (ch.ar) begin
						count_q <= ch.maxcount;
					end else begin
						// hold at zero, register block drops ce
						stopped_q <= 1'b1;
					end
				end else begin
					count_q <= count_q - 1'b1;
				end
			end
		end
	end

	assign ch.count = count_q;
	assign ch.out = out_q;
	assign ch.uflow = uflow_q;
	assign ch.stopped = stopped_q;

endmodule

// File: src/pit_pkg.sv
`include "pit_macros.svh"

package pit_pkg;

	// control byte of a channel, bit 0 is ld
	// members are listed msb first
	typedef struct packed {
		logic commit;
		logic [1:0] rsvd;
		logic ge;
		logic xc;
		logic ar;
		logic ce;
		logic ld;
	} pit_ctrl_t;

	// control byte sits in the low byte of the bus word
	typedef struct packed {
		logic [`PIT_DW-9:0] pad;
		pit_ctrl_t ctrl;
	} pit_ctrl_word_t;

	// one write word, decoded by the register addressed
	typedef union packed {
		logic [`PIT_DW-1:0] raw;
		pit_ctrl_word_t cw;
	} pit_wdata_u;

endpackage

// File: src/pit_regs.sv
`timescale 1ns/1ps
`include "pit_macros.svh"

module pit_regs (
	input logic clk,
	input logic rst,
	input logic req_i,
	input logic we_i,
	input logic [`PIT_AW-1:0] addr_i,
	input pit_pkg::pit_wdata_u wdata_i,
	output logic ack_o,
	output logic [`PIT_DW-1:0] rdata_o,
	output logic irq_o,
	pit_chan_if.regs ch [`PIT_NTIMER]
);

	localparam int CW = $clog2(`PIT_NTIMER);

	// bus side
	logic access;
	logic wr;
	logic ch_hit;
	logic [3:0] a_ch;
	logic [CW-1:0] a_idx;
	logic [3:0] a_ofs;
	logic [`PIT_DW-1:0] rd_val;
	pit_pkg::pit_ctrl_t rd_ctrl;

	// shadow and active values
	logic [`PIT_BITS-1:0] max_sh [`PIT_NTIMER];
	logic [`PIT_BITS-1:0] ont_sh [`PIT_NTIMER];
	logic [`PIT_BITS-1:0] max_act [`PIT_NTIMER];
	logic [`PIT_BITS-1:0] ont_act [`PIT_NTIMER];
	pit_pkg::pit_ctrl_t ctrl_sh [`PIT_NTIMER];

	// active control bits
	logic [`PIT_NTIMER-1:0] ld_q;
	logic [`PIT_NTIMER-1:0] ce_q;
	logic [`PIT_NTIMER-1:0] ar_q;
	logic [`PIT_NTIMER-1:0] xc_q;
	logic [`PIT_NTIMER-1:0] ge_q;

	// global state
	logic [`PIT_NTIMER-1:0] ie;
	logic [`PIT_NTIMER-1:0] igate;
	logic [`PIT_NTIMER-1:0] uflow_st;
	logic [`PIT_NTIMER-1:0] irqf;

	// collected from the counters
	logic [`PIT_BITS-1:0] count_a [`PIT_NTIMER];
	logic [`PIT_NTIMER-1:0] out_a;
	logic [`PIT_NTIMER-1:0] uflow_a;
	logic [`PIT_NTIMER-1:0] stopped_a;

	// ========================================
	// channel links
	// ========================================
	for (genvar g = 0; g < `PIT_NTIMER; g++) begin : g_link
		assign ch[g].ld = ld_q[g];
		assign ch[g].ce_set = ce_q[g];
		assign ch[g].ar = ar_q[g];
		assign ch[g].xc = xc_q[g];
		assign ch[g].ge = ge_q[g];
		assign ch[g].igate = igate[g];
		assign ch[g].maxcount = max_act[g];
		assign ch[g].ont = ont_act[g];
		assign count_a[g] = ch[g].count;
		assign out_a[g] = ch[g].out;
		assign uflow_a[g] = ch[g].uflow;
		assign stopped_a[g] = ch[g].stopped;
	end

	// ========================================
	// four-phase handshake
	// ========================================
	// access happens once per req, ack blocks a second one
	assign access = req_i && !ack_o;
	assign wr = access && we_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_o <= 1'b0;
		end else if (access) begin
			ack_o <= 1'b1;
		end else if (!req_i) begin
			ack_o <= 1'b0;
		end
	end

	// channel window is the lower half of the map
	assign a_ch = addr_i[`PIT_AW-2:4];
	assign a_idx = a_ch[CW-1:0];
	assign a_ofs = addr_i[3:0];
	assign ch_hit = !addr_i[`PIT_AW-1] && (a_ch < `PIT_NTIMER);

	// ========================================
	// read mux
	// ========================================
	always_comb begin
		rd_val = '0;
		rd_ctrl = '0;
		// reads show active state, ld and commit always read zero
		rd_ctrl.ce = ce_q[a_idx];
		rd_ctrl.ar = ar_q[a_idx];
		rd_ctrl.xc = xc_q[a_idx];
		rd_ctrl.ge = ge_q[a_idx];
		if (ch_hit) begin
			case (a_ofs)
				`PIT_OFS_COUNT: rd_val = count_a[a_idx];
				`PIT_OFS_MAX: rd_val = max_act[a_idx];
				`PIT_OFS_ONT: rd_val = ont_act[a_idx];
				`PIT_OFS_CTRL: rd_val = {{(`PIT_DW-8){1'b0}}, rd_ctrl};
				default: rd_val = '0;
			endcase
		end else begin
			case (addr_i)
				`PIT_REG_UFLOW: rd_val = {{(`PIT_DW-`PIT_NTIMER){1'b0}}, uflow_st};
				`PIT_REG_IE: rd_val = {{(`PIT_DW-`PIT_NTIMER){1'b0}}, ie};
				`PIT_REG_OUT: rd_val = {{(`PIT_DW-`PIT_NTIMER){1'b0}}, out_a};
				`PIT_REG_IGATE: rd_val = {{(`PIT_DW-`PIT_NTIMER){1'b0}}, igate};
				// sync, igset and igclr are write only
				default: rd_val = '0;
			endcase
		end
	end

	// read data is captured with the ack, writes return zero
	always_ff @(posedge clk) begin
		if (access) begin
			rdata_o <= we_i ? '0 : rd_val;
		end
	end

	// ========================================
	// register updates
	// ========================================
	always_ff @(posedge clk) begin
		if (rst) begin
			ld_q <= '0;
			ce_q <= '0;
			ar_q <= '1;
			xc_q <= '0;
			ge_q <= '0;
			ie <= '0;
			igate <= '0;
			uflow_st <= '0;
			irqf <= '0;
			irq_o <= 1'b0;
			for (int i = 0; i < `PIT_NTIMER; i++) begin
				max_sh[i] <= '0;
				ont_sh[i] <= '0;
				max_act[i] <= '0;
				ont_act[i] <= '0;
				ctrl_sh[i] <= '0;
				ctrl_sh[i].ar <= 1'b1;
			end
		end else begin
			// load is a single clock request
			ld_q <= '0;
			irq_o <= |irqf;
			if (wr) begin
				case (addr_i)
					`PIT_REG_IE: ie <= wdata_i.raw[`PIT_NTIMER-1:0];
					`PIT_REG_IGATE: igate <= wdata_i.raw[`PIT_NTIMER-1:0];
					`PIT_REG_IGSET: igate <= igate | wdata_i.raw[`PIT_NTIMER-1:0];
					`PIT_REG_IGCLR: igate <= igate & ~wdata_i.raw[`PIT_NTIMER-1:0];
					default: ;
				endcase
			end
			for (int i = 0; i < `PIT_NTIMER; i++) begin
				// counter events, a bus write in the same cycle wins
				if (stopped_a[i]) begin
					ce_q[i] <= 1'b0;
				end
				if (uflow_a[i]) begin
					uflow_st[i] <= 1'b1;
					if (ie[i]) begin
						irqf[i] <= 1'b1;
					end
				end
				if (wr && ch_hit && a_idx == CW'(i)) begin
					case (a_ofs)
						`PIT_OFS_MAX: max_sh[i] <= wdata_i.raw;
						`PIT_OFS_ONT: ont_sh[i] <= wdata_i.raw;
						`PIT_OFS_CTRL: begin
							ctrl_sh[i] <= wdata_i.cw.ctrl;
							ctrl_sh[i].commit <= 1'b0;
							// commit moves this word and both shadows to active
							if (wdata_i.cw.ctrl.commit) begin
								// load already issued, keep it out of a later sync
								ctrl_sh[i].ld <= 1'b0;
								ld_q[i] <= wdata_i.cw.ctrl.ld;
								ce_q[i] <= wdata_i.cw.ctrl.ce;
								ar_q[i] <= wdata_i.cw.ctrl.ar;
								xc_q[i] <= wdata_i.cw.ctrl.xc;
								ge_q[i] <= wdata_i.cw.ctrl.ge;
								max_act[i] <= max_sh[i];
								ont_act[i] <= ont_sh[i];
							end
						end
						default: ;
					endcase
				end
				// sync copies shadow state of every channel named in the mask
				if (wr && addr_i == `PIT_REG_SYNC && wdata_i.raw[i]) begin
					ld_q[i] <= ctrl_sh[i].ld;
					ce_q[i] <= ctrl_sh[i].ce;
					ar_q[i] <= ctrl_sh[i].ar;
					xc_q[i] <= ctrl_sh[i].xc;
					ge_q[i] <= ctrl_sh[i].ge;
					ctrl_sh[i].ld <= 1'b0;
					max_act[i] <= max_sh[i];
					ont_act[i] <= ont_sh[i];
				end
				// write one to clear status, flag and enable
				if (wr && addr_i == `PIT_REG_UFLOW && wdata_i.raw[i]) begin
					uflow_st[i] <= 1'b0;
					irqf[i] <= 1'b0;
					ie[i] <= 1'b0;
				end
			end
		end
	end

endmodule

// File: src/pit_top.sv
`timescale 1ns/1ps
`include "pit_macros.svh"

module pit_top (
	input logic clk,
	input logic rst,
	// host register bus
	input logic req_i,
	input logic we_i,
	input logic [`PIT_AW-1:0] addr_i,
	input logic [`PIT_DW-1:0] wdata_i,
	output logic ack_o,
	output logic [`PIT_DW-1:0] rdata_o,
	// timer pins, one bit per channel
	input logic [`PIT_NTIMER-1:0] ext_clk_i,
	input logic [`PIT_NTIMER-1:0] gate_i,
	output logic [`PIT_NTIMER-1:0] out_o,
	output logic irq_o
);

	// one link per channel
	pit_chan_if ch_if [`PIT_NTIMER] ();

	// ========================================
	// register block
	// ========================================
	pit_regs i_regs (
		.clk(clk),
		.rst(rst),
		.req_i(req_i),
		.we_i(we_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.ack_o(ack_o),
		.rdata_o(rdata_o),
		.irq_o(irq_o),
		.ch(ch_if)
	);

	// ========================================
	// channel counters
	// ========================================
	for (genvar g = 0; g < `PIT_NTIMER; g++) begin : g_chan
		pit_counter i_counter (
			.clk(clk),
			.rst(rst),
			.ext_clk_i(ext_clk_i[g]),
			.gate_i(gate_i[g]),
			.ch(ch_if[g])
		);

		assign out_o[g] = ch_if[g].out;
	end

endmodule
